// File: apb_entity_regs.sv
// APB slave holding the eight entity slots and the two palette colours.
// Zero-wait-state: pready is high in every access phase.
// Addresses above REG_BG raise pslverr, writes there are dropped.
// The whole register file is presented to the scan pipeline every cycle.
`default_nettype none
`timescale 1ns/100ps

module apb_entity_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [3:0]               paddr,
  input  logic [15:0]              pwdata,
  output logic [15:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output sprite_pkg::entity_bank_t bank,
  output logic [7:0]               fg,
  output logic [7:0]               bg
);
  import sprite_pkg::*;

  logic       access;    // Access phase of a transfer
  logic       addr_bad;  // Outside the register map
  logic       wr_en;
  logic [3:0] slot_off;  // Offset from the slot base
  logic       is_slot;
  logic [2:0] slot;

  assign access   = psel & penable;
  assign addr_bad = paddr > REG_BG;
  assign slot_off = paddr - REG_ENTITY_BASE;
  assign is_slot  = slot_off < 4'(NUM_ENTITIES);
  assign slot     = slot_off[2:0];

  assign pready  = access;              // Never stretches the access phase
  assign pslverr = access & addr_bad;
  assign wr_en   = access & pwrite & ~addr_bad;

  // Register writes land on the edge that closes the access phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ENTITIES; i++) begin
        bank[i] <= '{id: ENTITY_UNUSED, orient: 2'd0, loc: 8'd0};  // All slots empty
      end
      fg <= 8'hFF;  // White on black by default
      bg <= 8'h00;
    end else if (wr_en) begin
      if (is_slot) begin
        bank[slot] <= entity_t'(pwdata[13:0]);  // Upper two data bits ignored
      end else if (paddr == REG_FG) begin
        fg <= pwdata[7:0];
      end else begin
        bg <= pwdata[7:0];  // Only REG_BG left
      end
    end
  end

  // Read data straight from storage
  always_comb begin
    prdata = 16'h0000;  // Bad addresses read as zero
    if (!addr_bad) begin
      if (is_slot) begin
        prdata = {2'b00, bank[slot]};
      end else if (paddr == REG_FG) begin
        prdata = {8'h00, fg};
      end else begin
        prdata = {8'h00, bg};
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sprite VGA testbench with Verilator and runs it.
# Exit status is nonzero when the build fails or the log shows a failure.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module tb_sprite_vga -o sim_tb \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > "$LOG" 2>&1
cat "$LOG"
grep -q "FAIL: see errors above" "$LOG" \
  && { echo "Simulation reported errors"; exit 1; }
grep -q "PASS: all tests" "$LOG" \
  || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// File: sprite_fetch.sv
// Second pipeline stage of the scan path.
// Turns the on-screen sprite coordinates into bitmap coordinates
// according to the entity orientation and reads one bit of the
// sprite table. A miss in tile lookup always gives a clear pixel.
`default_nettype none
`timescale 1ns/100ps

module sprite_fetch (
  input  logic                  clk,
  input  logic                  rst_n,
  input  sprite_pkg::tile_hit_t hit,
  output sprite_pkg::pix_t      pix
);
  import sprite_pkg::*;

  logic [2:0] col;       // Bitmap column
  logic [2:0] row;       // Bitmap row
  logic [7:0] row_bits;
  logic       bit_on;

  // 7-n on three bits is just the inverse
  always_comb begin
    case (hit.orient)
      2'd0: begin
        col = hit.px;
        row = hit.py;
      end
      2'd1: begin        // 90 cw
        col = hit.py;
        row = ~hit.px;
      end
      2'd2: begin        // 180
        col = ~hit.px;
        row = ~hit.py;
      end
      default: begin     // 270 cw
        col = ~hit.py;
        row = hit.px;
      end
    endcase
  end

  // ID 15 has no bitmap
  assign row_bits = (hit.id == ENTITY_UNUSED) ? 8'h00 : SPRITE_ROM[hit.id][row];
  assign bit_on   = hit.hit & row_bits[~col];  // Bit 7 is leftmost

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix <= '{on: 1'b0, active: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1};
    end else begin
      pix <= '{
        on:      bit_on,
        active:  hit.active,
        hsync_n: hit.hsync_n,
        vsync_n: hit.vsync_n
      };
    end
  end

endmodule

`default_nettype wire

// File: sprite_pkg.sv
// Shared definitions for the tile-and-sprite VGA engine.
// Holds the 640x480 timing constants, the entity and pipeline records,
// the APB register map and the 8x8 sprite bitmaps.
// Modules name these types in their port lists and import the rest.
`default_nettype none

package sprite_pkg;

  localparam int H_ACTIVE = 640;  // Visible pixels per line
  localparam int H_FRONT  = 16;   // Front porch
  localparam int H_SYNC   = 96;   // Sync pulse width
  localparam int H_TOTAL  = 800;  // Full line incl. back porch

  localparam int V_ACTIVE = 480;  // Visible lines
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_TOTAL  = 525;

  localparam int         NUM_ENTITIES  = 8;
  localparam logic [3:0] ENTITY_UNUSED = 4'hF;  // Empty slot marker

  localparam logic [3:0] REG_ENTITY_BASE = 4'd0;  // Slots 0..7
  localparam logic [3:0] REG_FG          = 4'd8;
  localparam logic [3:0] REG_BG          = 4'd9;

  typedef struct packed {
    logic [3:0] id;      // Sprite ID
    logic [1:0] orient;  // Quarter turns clockwise
    logic [7:0] loc;     // {tile row, tile column}
  } entity_t;

  typedef entity_t [NUM_ENTITIES-1:0] entity_bank_t;

  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       active;
    logic       hsync_n;
    logic       vsync_n;
  } scan_t;

  typedef struct packed {
    logic       hit;     // Some slot sits on this tile
    logic [3:0] id;
    logic [1:0] orient;
    logic [2:0] px;      // Sprite column on screen
    logic [2:0] py;      // Sprite row on screen
    logic       active;
    logic       hsync_n;
    logic       vsync_n;
  } tile_hit_t;

  typedef struct packed {
    logic on;  // Sprite bit after rotation
    logic active;
    logic hsync_n;
    logic vsync_n;
  } pix_t;

  // Bit 7 of each row is the leftmost pixel
  localparam logic [7:0] SPRITE_ROM [0:14][0:7] = '{
    '{8'h18, 8'h0C, 8'h06, 8'hFF, 8'hFF, 8'h06, 8'h0C, 8'h18},  // Arrow right
    '{8'hFE, 8'hFE, 8'hC0, 8'hFC, 8'hFC, 8'hC0, 8'hC0, 8'hC0},  // Letter F
    '{8'h66, 8'hFF, 8'hFF, 8'hFF, 8'h7E, 8'h3C, 8'h18, 8'h00},  // Heart
    '{8'h3C, 8'h42, 8'hA5, 8'h81, 8'hA5, 8'h99, 8'h42, 8'h3C},  // Face
    '{8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'h80, 8'hFF},  // Corner
    '{8'hAA, 8'h55, 8'hAA, 8'h55, 8'hAA, 8'h55, 8'hAA, 8'h55},  // Checker
    '{8'hFF, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'h81, 8'hFF},  // Box
    '{8'h18, 8'h3C, 8'h7E, 8'hFF, 8'h7E, 8'h3C, 8'h18, 8'h00},  // Diamond
    '{8'h18, 8'h3C, 8'h7E, 8'hDB, 8'hFF, 8'h24, 8'h5A, 8'h81},  // Ship
    '{8'h18, 8'h3C, 8'h7E, 8'hFF, 8'h18, 8'h18, 8'h18, 8'h3C},  // Tree
    '{8'hF0, 8'hFC, 8'hFF, 8'hFC, 8'hF0, 8'h80, 8'h80, 8'h80},  // Flag
    '{8'h70, 8'h88, 8'h88, 8'h70, 8'h20, 8'h38, 8'h20, 8'h38},  // Key
    '{8'h7E, 8'hDB, 8'hDB, 8'hFF, 8'hE7, 8'h7E, 8'h5A, 8'h00},  // Skull
    '{8'h01, 8'h03, 8'h07, 8'h0F, 8'h1F, 8'h3F, 8'h7F, 8'hFF},  // Stairs
    '{8'h80, 8'h40, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02, 8'h01}   // Diagonal
  };

endpackage

`default_nettype wire

// File: sprite_vga_top.sv
// Top of the sprite display engine.
// The host programs entities and colours over APB. A scan generator
// feeds tile lookup, sprite fetch and the output stage, so the pins
// lag the scan position by three clocks.
`default_nettype none
`timescale 1ns/100ps

module sprite_vga_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [15:0] pwdata,
  output logic [15:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic [7:0]  rgb,
  output logic        hsync_n,
  output logic        vsync_n
);
  import sprite_pkg::*;

  entity_bank_t bank;
  logic [7:0]   fg;
  logic [7:0]   bg;
  scan_t        scan;   // Stage 0 position
  tile_hit_t    hit;    // After tile lookup
  pix_t         pix;    // After sprite fetch

  apb_entity_regs u_regs (
    .clk, .rst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .bank, .fg, .bg
  );

  vga_timing u_timing (.clk, .rst_n, .scan);

  tile_match u_tile (.clk, .rst_n, .scan, .bank, .hit);

  sprite_fetch u_fetch (.clk, .rst_n, .hit, .pix);

  vga_out u_out (
    .clk, .rst_n,
    .pix, .fg, .bg,
    .rgb, .hsync_n, .vsync_n
  );

endmodule

`default_nettype wire

// File: tb.f
sprite_pkg.sv
apb_entity_regs.sv
vga_timing.sv
tile_match.sv
sprite_fetch.sv
vga_out.sv
sprite_vga_top.sv
tb_sprite_vga.sv

// File: tb_sprite_vga.sv
// Self-checking testbench for the sprite VGA engine.
// Programs entity slots and colours over APB and keeps a shadow copy.
// A compare process checks rgb and both syncs on every clock against
// a reference pixel model while the registers are stable.
// The run stops at the first mismatch or timeout.
`default_nettype none
`timescale 1ns/100ps

module tb_sprite_vga;
  import sprite_pkg::*;

  localparam int          FRAME = H_TOTAL * V_TOTAL;  // Clocks per frame
  localparam logic [31:0] SEED  = 32'ha0db03b2;

  logic         clk;
  logic         rst_n;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [3:0]   paddr;
  logic [15:0]  pwdata;
  logic [15:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic [7:0]   rgb;
  logic         hsync_n;
  logic         vsync_n;
  entity_bank_t shadow_bank;  // Expected register contents
  logic [7:0]   shadow_fg;
  logic [7:0]   shadow_bg;
  logic         check_en;     // Comparer armed
  logic [31:0]  rng;
  int           cyc = 0;      // Rising edges since reset release

  sprite_vga_top uut (
    .clk, .rst_n,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .rgb, .hsync_n, .vsync_n
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 125 MHz
  end

  always @(posedge clk) begin
    if (!rst_n) cyc <= 0;
    else cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Expected {rgb, hsync_n, vsync_n} for scan position (x, y)
  function automatic logic [9:0] expect_pixel(input entity_bank_t b, input logic [7:0] f,
                                               input logic [7:0] g, input int x, input int y);
    logic [3:0] tc;
    logic [3:0] tr;
    logic       found;
    logic       on;
    logic       hs;
    logic       vs;
    logic [7:0] colour;
    int         px;
    int         py;
    int         c;
    int         r;
    int         k;
    tc    = 4'(x / 32);  // Same as x[8:5]
    tr    = 4'(y / 32);
    px    = (x / 4) % 8;
    py    = (y / 4) % 8;
    found = 1'b0;
    k     = 0;
    for (int i = 0; i < NUM_ENTITIES; i++) begin
      if (!found && b[i].id != ENTITY_UNUSED && b[i].loc == {tr, tc}) begin
        found = 1'b1;  // Lowest slot wins
        k     = i;
      end
    end
    case (b[k].orient)
      2'd0: begin
        c = px;
        r = py;
      end
      2'd1: begin
        c = py;
        r = 7 - px;
      end
      2'd2: begin
        c = 7 - px;
        r = 7 - py;
      end
      default: begin
        c = 7 - py;
        r = px;
      end
    endcase
    on     = found && SPRITE_ROM[b[k].id][r][7 - c];
    colour = on ? f : g;
    if (x >= H_ACTIVE || y >= V_ACTIVE) colour = 8'h00;  // Blanking
    hs = !(x >= H_ACTIVE + H_FRONT && x < H_ACTIVE + H_FRONT + H_SYNC);
    vs = !(y >= V_ACTIVE + V_FRONT && y < V_ACTIVE + V_FRONT + V_SYNC);
    return {colour, hs, vs};
  endfunction

  function automatic logic [15:0] reg_value(input int a);
    if (a < NUM_ENTITIES) return {2'b00, shadow_bank[a]};
    if (a == int'(REG_FG)) return {8'h00, shadow_fg};
    if (a == int'(REG_BG)) return {8'h00, shadow_bg};
    return 16'h0000;  // Unmapped
  endfunction

  function automatic int out_index();
    return (cyc - 3) % FRAME;  // Scan index now at the pins
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("FAIL %s: got 0x%0h expected 0x%0h at %0t",
                          name, got, exp, $time));
    end
  endtask

  // One APB transfer, setup then access phase, starts after a rising edge
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [15:0] data,
                            output logic [15:0] rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    while (n < 16) begin
      @(negedge clk);
      if (pready === 1'b1) break;
      n++;
    end
    if (n >= 16) fail_stop("Timeout: pready never rose in the APB access phase");
    check_value("pready wait states", 32'(n), 32'd0);  // Zero-wait-state slave
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);  // Write lands here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [15:0] data, output logic err);
    logic [15:0] unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [15:0] data, output logic err);
    apb_access(1'b0, addr, 16'h0000, data, err);
  endtask

  task automatic write_slot(input int i, input entity_t e);
    logic err;
    apb_write(4'(i), {2'b00, e}, err);
    check_value("pslverr", 32'(err), 32'd0);
    shadow_bank[i] = e;
  endtask

  task automatic write_colour(input logic [3:0] addr, input logic [7:0] c);
    logic err;
    apb_write(addr, {8'h00, c}, err);
    check_value("pslverr", 32'(err), 32'd0);
    if (addr == REG_FG) shadow_fg = c;
    else shadow_bg = c;
  endtask

  // Pipeline flush after register writes, three stages deep
  task automatic settle();
    repeat (4) @(posedge clk);
    #1 check_en = 1'b1;
  endtask

  task automatic wait_scan(input int line, input int px);
    int n;
    n = 0;
    while (n < FRAME + 16) begin
      @(negedge clk);
      if (cyc >= 3 && out_index() == line * H_TOTAL + px) break;
      n++;
    end
    if (n >= FRAME + 16) fail_stop($sformatf("Timeout: output never reached line %0d", line));
  endtask

  task automatic wait_sync(input bit vert, input logic level, input int limit, output int at);
    int n;
    n = 0;
    while (n < limit) begin
      @(negedge clk);
      if ((vert ? vsync_n : hsync_n) === level) break;
      n++;
    end
    if (n >= limit) fail_stop("Timeout: sync output never reached the expected level");
    at = cyc;
  endtask

  // Lines first..stop-1 pass through the comparer
  task automatic check_lines(input int first, input int stop);
    wait_scan(first, 0);
    wait_scan(stop, 0);
  endtask

  always @(negedge clk) begin : compare_outputs
    logic [9:0] exp_out;
    int         idx;
    if (check_en) begin
      if (!rst_n || cyc < 3) begin
        exp_out = {8'h00, 1'b1, 1'b1};  // Pipeline still filling
      end else begin
        idx     = out_index();
        exp_out = expect_pixel(shadow_bank, shadow_fg, shadow_bg,
                               idx % H_TOTAL, idx / H_TOTAL);
      end
      check_value("rgb", 32'(rgb), 32'(exp_out[9:2]));
      check_value("hsync_n", 32'(hsync_n), 32'(exp_out[1]));
      check_value("vsync_n", 32'(vsync_n), 32'(exp_out[0]));
    end
  end

  initial begin
    entity_t     e;
    entity_t     empty;
    logic [15:0] rd;
    logic        err;
    int          t_fall;
    int          t_rise;
    int          t_next;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = 4'd0;
    pwdata   = 16'h0000;
    rst_n    = 1'b0;
    check_en = 1'b1;
    rng      = SEED;
    empty    = '{id: ENTITY_UNUSED, orient: 2'd0, loc: 8'h00};
    for (int i = 0; i < NUM_ENTITIES; i++) shadow_bank[i] = empty;
    shadow_fg = 8'hFF;
    shadow_bg = 8'h00;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // Defaults, then a bad address that must change nothing
    for (int a = 0; a < 10; a++) begin
      apb_read(4'(a), rd, err);
      check_value("prdata", 32'(rd), 32'(reg_value(a)));
      check_value("pslverr", 32'(err), 32'd0);
    end
    apb_write(4'd12, 16'h3FFF, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_read(4'd12, rd, err);
    check_value("pslverr", 32'(err), 32'd1);
    check_value("prdata", 32'(rd), 32'd0);
    for (int a = 0; a < 10; a++) begin
      apb_read(4'(a), rd, err);
      check_value("prdata", 32'(rd), 32'(reg_value(a)));
    end

    // Sync shape over two lines, then the vertical pulse
    wait_sync(1'b0, 1'b1, H_TOTAL + 8, t_fall);
    wait_sync(1'b0, 1'b0, H_TOTAL + 8, t_fall);
    for (int l = 0; l < 2; l++) begin
      wait_sync(1'b0, 1'b1, H_TOTAL + 8, t_rise);
      wait_sync(1'b0, 1'b0, H_TOTAL + 8, t_next);
      check_value("hsync_n low width", 32'(t_rise - t_fall), 32'(H_SYNC));
      check_value("hsync_n period", 32'(t_next - t_fall), 32'(H_TOTAL));
      t_fall = t_next;
    end
    wait_sync(1'b1, 1'b0, FRAME + 16, t_fall);
    check_value("vsync_n start line", 32'(out_index() / H_TOTAL), 32'(V_ACTIVE + V_FRONT));
    check_value("vsync_n start pixel", 32'(out_index() % H_TOTAL), 32'd0);

    // Random slots in tile rows 0 and 1
    check_en = 1'b0;
    for (int i = 0; i < NUM_ENTITIES; i++) begin
      rng = xorshift(rng);
      e   = '{id: 4'(rng % 15), orient: rng[5:4], loc: {3'b000, rng[8], rng[15:12]}};
      write_slot(i, e);
    end
    settle();
    check_lines(0, 64);

    // Letter F in all four orientations along tile row 2
    check_en = 1'b0;
    for (int i = 0; i < NUM_ENTITIES; i++) begin
      if (i < 4) write_slot(i, '{id: 4'd1, orient: 2'(i), loc: 8'h20 + 8'(i)});
      else write_slot(i, empty);
    end
    settle();
    check_lines(64, 96);

    // Overlap on tile (0,0), lower slot first, then only slot 5
    check_en = 1'b0;
    for (int i = 0; i < NUM_ENTITIES; i++) begin
      if (i == 2) write_slot(i, '{id: 4'd2, orient: 2'd0, loc: 8'h00});
      else if (i == 5) write_slot(i, '{id: 4'd3, orient: 2'd0, loc: 8'h00});
      else write_slot(i, empty);
    end
    settle();
    check_lines(0, 32);
    check_en = 1'b0;
    write_slot(2, empty);
    settle();
    check_lines(0, 32);

    // New palette, blanking must stay black
    check_en = 1'b0;
    write_colour(REG_FG, 8'h5A);
    write_colour(REG_BG, 8'h93);
    settle();
    check_lines(0, V_ACTIVE + 2);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: tile_match.sv
// First pipeline stage of the scan path.
// Each sprite pixel is 4x4 screen pixels, so a tile is 32x32.
// Finds which entity slot occupies the tile under the beam and passes
// its ID and orientation on with the in-sprite coordinates.
// On overlap the lowest slot index wins.
`default_nettype none
`timescale 1ns/100ps

module tile_match (
  input  logic                     clk,
  input  logic                     rst_n,
  input  sprite_pkg::scan_t        scan,
  input  sprite_pkg::entity_bank_t bank,
  output sprite_pkg::tile_hit_t    hit
);
  import sprite_pkg::*;

  logic [3:0] tile_col;
  logic [3:0] tile_row;
  logic [7:0] tile_loc;  // Same layout as entity loc
  logic       found;
  logic [2:0] sel;       // Winning slot

  assign tile_col = scan.x[8:5];
  assign tile_row = scan.y[8:5];
  assign tile_loc = {tile_row, tile_col};

  // Walk downward so the lowest matching slot is the last one kept
  always_comb begin
    found = 1'b0;
    sel   = 3'd0;
    for (int i = NUM_ENTITIES - 1; i >= 0; i--) begin
      if ((bank[i].id != ENTITY_UNUSED) && (bank[i].loc == tile_loc)) begin
        found = 1'b1;
        sel   = 3'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit <= '{
        hit:     1'b0,
        id:      4'd0,
        orient:  2'd0,
        px:      3'd0,
        py:      3'd0,
        active:  1'b0,  // Blank until real data arrives
        hsync_n: 1'b1,
        vsync_n: 1'b1
      };
    end else begin
      hit <= '{
        hit:     found,
        id:      bank[sel].id,
        orient:  bank[sel].orient,
        px:      scan.x[4:2],  // Drop the 4x scale
        py:      scan.y[4:2],
        active:  scan.active,
        hsync_n: scan.hsync_n,
        vsync_n: scan.vsync_n
      };
    end
  end

endmodule

`default_nettype wire

// File: vga_out.sv
// Last pipeline stage that drives the VGA pins.
// Picks fg for a set sprite bit and bg otherwise, and forces black
// outside the visible area. All pins leave from flops.
`default_nettype none
`timescale 1ns/100ps

module vga_out (
  input  logic             clk,
  input  logic             rst_n,
  input  sprite_pkg::pix_t pix,
  input  logic [7:0]       fg,
  input  logic [7:0]       bg,
  output logic [7:0]       rgb,
  output logic             hsync_n,
  output logic             vsync_n
);

  logic [7:0] colour;

  // Blanking overrides the palette
  assign colour = !pix.active ? 8'h00 : (pix.on ? fg : bg);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb     <= 8'h00;
      hsync_n <= 1'b1;  // Syncs idle high
      vsync_n <= 1'b1;
    end else begin
      rgb     <= colour;
      hsync_n <= pix.hsync_n;
      vsync_n <= pix.vsync_n;
    end
  end

endmodule

`default_nettype wire

// File: vga_timing.sv
// Scan generator for 640x480 in an 800x525 frame.
// Two free-running counters give the position, and active and both syncs
// are registered alongside so the record leaving here is glitch free.
// Out of reset the record shows position (0,0).
`default_nettype none
`timescale 1ns/100ps

module vga_timing (
  input  logic              clk,
  input  logic              rst_n,
  output sprite_pkg::scan_t scan
);
  import sprite_pkg::*;

  logic [9:0] h_cnt;     // Pixel within line
  logic [9:0] v_cnt;     // Line within frame
  logic [9:0] h_nxt;
  logic [9:0] v_nxt;
  logic       h_wrap;    // Last pixel of the line
  logic       active_q;
  logic       hsync_q;
  logic       vsync_q;

  always_comb begin
    h_wrap = h_cnt == 10'(H_TOTAL - 1);
    h_nxt  = h_wrap ? 10'd0 : h_cnt + 10'd1;
    v_nxt  = v_cnt;
    if (h_wrap) begin
      v_nxt = (v_cnt == 10'(V_TOTAL - 1)) ? 10'd0 : v_cnt + 10'd1;  // Frame wrap
    end
  end

  // Flags follow the next position so they stay aligned with the counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt    <= 10'd0;
      v_cnt    <= 10'd0;
      active_q <= 1'b1;  // (0,0) is visible
      hsync_q  <= 1'b1;
      vsync_q  <= 1'b1;
    end else begin
      h_cnt    <= h_nxt;
      v_cnt    <= v_nxt;
      active_q <= (h_nxt < 10'(H_ACTIVE)) && (v_nxt < 10'(V_ACTIVE));
      hsync_q  <= !((h_nxt >= 10'(H_ACTIVE + H_FRONT)) &&
                    (h_nxt <  10'(H_ACTIVE + H_FRONT + H_SYNC)));  // Low 656..751
      vsync_q  <= !((v_nxt >= 10'(V_ACTIVE + V_FRONT)) &&
                    (v_nxt <  10'(V_ACTIVE + V_FRONT + V_SYNC)));  // Low 490..491
    end
  end

  assign scan = '{
    x:       h_cnt,
    y:       v_cnt,
    active:  active_q,
    hsync_n: hsync_q,
    vsync_n: vsync_q
  };

endmodule

`default_nettype wire
